// File: include/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

//////////////////////////////
// memory array
//////////////////////////////

// number of 64-bit words in main memory
`define MEM_64BIT_LINES 256
// byte size, first address that is out of range
`define MEM_SIZE_IN_BYTES (8 * `MEM_64BIT_LINES)

//////////////////////////////
// memory pipeline
//////////////////////////////

// outstanding ops, tag 0 is reserved for none
`define NUM_MEM_TAGS 15
// min cycles from acceptance to data return
`define MEM_LATENCY_IN_CYCLES 4

// client entries held in the request queue
`define REQ_QUEUE_DEPTH 8

`endif

// File: mem_subsys.f
+incdir+include
rtl/bus_pkg.sv
rtl/req_pkg.sv
rtl/mem.sv
rtl/mem_req_queue.sv
rtl/mem_subsys.sv
sim/mem_subsys_tb.sv

// File: rtl/bus_pkg.sv
`default_nettype none

//////////////////////////////
// processor-memory bus
//////////////////////////////

package bus_pkg;

	// bus command, none means idle bus
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_t;

	// byte address, low three bits select the byte in a word
	typedef logic [63:0] bus_addr_t;

	// one memory word
	typedef logic [63:0] bus_data_t;

	// memory tag
	// zero means no tag / request refused
	typedef logic [3:0] mem_tag_t;

endpackage

`default_nettype wire

// File: rtl/mem.sv
`default_nettype none

`include "mem_config.svh"

module mem (
	input  logic                clock,
	input  logic                rst,
	input  bus_pkg::bus_addr_t  proc2mem_addr,
	input  bus_pkg::bus_data_t  proc2mem_data,
	input  bus_pkg::bus_cmd_t   proc2mem_command,
	output bus_pkg::mem_tag_t   mem2proc_response,
	output bus_pkg::bus_data_t  mem2proc_data,
	output bus_pkg::mem_tag_t   mem2proc_tag
);

	import bus_pkg::*;

	localparam int NTAGS  = `NUM_MEM_TAGS;
	localparam int LINE_W = $clog2(`MEM_64BIT_LINES);
	localparam int CNT_W  = $clog2(`MEM_LATENCY_IN_CYCLES + 1);

	typedef logic [LINE_W-1:0] line_idx_t;
	typedef logic [CNT_W-1:0] cnt_t;

	// word storage
	bus_data_t unified_memory [`MEM_64BIT_LINES];
	// lines stored since reset, others read as zero
	logic [`MEM_64BIT_LINES-1:0] line_written;

	// per-tag state
	bus_data_t loaded_data [1:NTAGS];
	cnt_t cycles_left [1:NTAGS];
	logic [NTAGS:1] waiting_for_bus;

	mem_tag_t acc_tag;
	mem_tag_t ret_tag;
	logic acquire;
	line_idx_t line_idx;

	// word address only, range check lives in the queue
	assign line_idx = proc2mem_addr[3 +: LINE_W];

	//////////////////////////////
	// tag selection
	//////////////////////////////

	// walk down so the lowest tag wins
	always_comb begin
		acc_tag = '0;
		ret_tag = '0;
		for (int i = NTAGS; i >= 1; i--) begin
			// free: no countdown, no data parked
			if (cycles_left[i] == '0 && !waiting_for_bus[i])
				acc_tag = mem_tag_t'(i);
			// ready: countdown done, data parked
			if (cycles_left[i] == '0 && waiting_for_bus[i])
				ret_tag = mem_tag_t'(i);
		end
	end

	// refused when every tag is busy
	assign acquire = (proc2mem_command == BUS_LOAD || proc2mem_command == BUS_STORE)
		&& acc_tag != '0;

	//////////////////////////////
	// control state
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			mem2proc_response <= '0;
			mem2proc_tag <= '0;
			line_written <= '0;
			waiting_for_bus <= '0;
			for (int i = 1; i <= NTAGS; i++)
				cycles_left[i] <= '0;
		end else begin
			// response seen by the queue one cycle after the command
			mem2proc_response <= acquire ? acc_tag : '0;
			mem2proc_tag <= ret_tag;
			// countdowns
			for (int i = 1; i <= NTAGS; i++) begin
				if (cycles_left[i] != '0)
					cycles_left[i] <= cycles_left[i] - 1'b1;
			end
			// winner leaves the bus queue
			if (ret_tag != '0)
				waiting_for_bus[ret_tag] <= 1'b0;
			if (acquire) begin
				// minus one since the return is registered
				cycles_left[acc_tag] <= cnt_t'(`MEM_LATENCY_IN_CYCLES - 1);
				if (proc2mem_command == BUS_LOAD)
					waiting_for_bus[acc_tag] <= 1'b1;
				else
					line_written[line_idx] <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// array and data path
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (acquire && proc2mem_command == BUS_STORE)
			unified_memory[line_idx] <= proc2mem_data;
		// load samples the array at acceptance
		if (acquire && proc2mem_command == BUS_LOAD)
			loaded_data[acc_tag] <= line_written[line_idx] ? unified_memory[line_idx] : '0;
		// single return bus
		mem2proc_data <= (ret_tag != '0) ? loaded_data[ret_tag] : '0;
	end

endmodule

`default_nettype wire

// File: rtl/mem_req_queue.sv
`default_nettype none

`include "mem_config.svh"

module mem_req_queue (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 req_valid,
	output logic                 req_ready,
	input  bus_pkg::bus_cmd_t    req_cmd,
	input  bus_pkg::bus_addr_t   req_addr,
	input  bus_pkg::bus_data_t   req_data,
	input  req_pkg::client_id_t  req_id,
	output logic                 done_valid,
	output req_pkg::client_id_t  done_id,
	output bus_pkg::bus_data_t   done_data,
	output logic                 done_store,
	output logic                 done_err,
	output bus_pkg::bus_cmd_t    proc2mem_command,
	output bus_pkg::bus_addr_t   proc2mem_addr,
	output bus_pkg::bus_data_t   proc2mem_data,
	input  bus_pkg::mem_tag_t    mem2proc_response,
	input  bus_pkg::bus_data_t   mem2proc_data,
	input  bus_pkg::mem_tag_t    mem2proc_tag
);

	import bus_pkg::*;
	import req_pkg::*;

	localparam int DEPTH = `REQ_QUEUE_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// entry payload
	bus_addr_t e_addr [DEPTH];
	bus_data_t e_data [DEPTH];
	client_id_t e_id [DEPTH];
	mem_tag_t e_tag [DEPTH];
	logic [DEPTH-1:0] e_load;
	// entry control
	logic [DEPTH-1:0] e_valid;
	logic [DEPTH-1:0] e_issued;

	// head = oldest slot of the span, tail = next alloc
	queue_idx_t head, tail, iss_ptr;
	logic [CNT_W-1:0] count;
	issue_state_t state;

	// one-deep holding registers for the done bus
	logic rej_valid, rej_store;
	client_id_t rej_id;
	logic st_pend_valid;
	client_id_t st_pend_id;

	logic bad_req, alloc, reject, head_adv;
	logic drive, accept, st_now;
	logic ret_hit;
	queue_idx_t ret_idx;

	function automatic queue_idx_t idx_inc(input queue_idx_t p);
		return (p == queue_idx_t'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	//////////////////////////////
	// client side
	//////////////////////////////

	// misaligned, out of range or no real command
	assign bad_req = (req_addr[2:0] != 3'b000)
		|| (req_addr >= bus_addr_t'(`MEM_SIZE_IN_BYTES))
		|| !(req_cmd == BUS_LOAD || req_cmd == BUS_STORE);
	assign alloc = req_valid && !bad_req;
	assign reject = req_valid && bad_req;

	// span shrinks past freed slots from the old end
	assign head_adv = (count != '0) && !e_valid[head];
	assign req_ready = (count < CNT_W'(DEPTH)) && !rej_valid;

	//////////////////////////////
	// issue side
	//////////////////////////////

	// hold issue while a store completion is parked
	assign drive = (state == ISSUE_IDLE) && e_valid[iss_ptr] && !e_issued[iss_ptr]
		&& !st_pend_valid;
	assign accept = (state == ISSUE_WAIT) && (mem2proc_response != '0);
	assign st_now = accept && !e_load[iss_ptr];

	// one-cycle command, bus idle in the wait state
	assign proc2mem_command = drive ? (e_load[iss_ptr] ? BUS_LOAD : BUS_STORE) : BUS_NONE;
	assign proc2mem_addr = e_addr[iss_ptr];
	assign proc2mem_data = e_data[iss_ptr];

	// match a returning tag to an issued load
	always_comb begin
		ret_hit = 1'b0;
		ret_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (e_valid[i] && e_issued[i] && e_load[i] && mem2proc_tag != '0
				&& e_tag[i] == mem2proc_tag) begin
				ret_hit = 1'b1;
				ret_idx = queue_idx_t'(i);
			end
		end
	end

	//////////////////////////////
	// done bus
	//////////////////////////////

	// load return first, it cannot be held
	assign done_valid = ret_hit || st_now || st_pend_valid || rej_valid;

	always_comb begin
		done_id = '0;
		done_data = '0;
		done_store = 1'b0;
		done_err = 1'b0;
		if (ret_hit) begin
			done_id = e_id[ret_idx];
			done_data = mem2proc_data;
		end else if (st_now) begin
			done_id = e_id[iss_ptr];
			done_store = 1'b1;
		end else if (st_pend_valid) begin
			done_id = st_pend_id;
			done_store = 1'b1;
		end else if (rej_valid) begin
			done_id = rej_id;
			done_store = rej_store;
			done_err = 1'b1;
		end
	end

	//////////////////////////////
	// control state
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			iss_ptr <= '0;
			count <= '0;
			state <= ISSUE_IDLE;
			e_valid <= '0;
			e_issued <= '0;
			rej_valid <= 1'b0;
			st_pend_valid <= 1'b0;
		end else begin
			if (alloc) begin
				e_valid[tail] <= 1'b1;
				e_issued[tail] <= 1'b0;
				tail <= idx_inc(tail);
			end
			if (head_adv)
				head <= idx_inc(head);
			count <= count + CNT_W'(alloc) - CNT_W'(head_adv);
			// issue fsm
			case (state)
				ISSUE_IDLE: begin
					if (drive)
						state <= ISSUE_WAIT;
				end
				ISSUE_WAIT: begin
					// zero response leaves iss_ptr, same entry goes again
					state <= ISSUE_IDLE;
					if (accept) begin
						iss_ptr <= idx_inc(iss_ptr);
						// stores are done at acceptance
						if (e_load[iss_ptr])
							e_issued[iss_ptr] <= 1'b1;
						else
							e_valid[iss_ptr] <= 1'b0;
					end
				end
				default: state <= ISSUE_IDLE;
			endcase
			// load data back, slot freed out of order
			if (ret_hit) begin
				e_valid[ret_idx] <= 1'b0;
				e_issued[ret_idx] <= 1'b0;
			end
			// store completion lost the done bus
			if (st_now && ret_hit)
				st_pend_valid <= 1'b1;
			else if (st_pend_valid && !ret_hit)
				st_pend_valid <= 1'b0;
			// rejection drains when no memory completion
			if (rej_valid && !ret_hit && !st_now && !st_pend_valid)
				rej_valid <= 1'b0;
			if (reject)
				rej_valid <= 1'b1;
		end
	end

	// payload, no reset
	always_ff @(posedge clock) begin
		if (alloc) begin
			e_addr[tail] <= req_addr;
			e_data[tail] <= req_data;
			e_id[tail] <= req_id;
			e_load[tail] <= (req_cmd == BUS_LOAD);
		end
		if (accept)
			e_tag[iss_ptr] <= mem2proc_response;
		if (st_now && ret_hit)
			st_pend_id <= e_id[iss_ptr];
		if (reject) begin
			rej_id <= req_id;
			rej_store <= (req_cmd == BUS_STORE);
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_subsys.sv
`default_nettype none

module mem_subsys (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 req_valid,
	output logic                 req_ready,
	input  bus_pkg::bus_cmd_t    req_cmd,
	input  bus_pkg::bus_addr_t   req_addr,
	input  bus_pkg::bus_data_t   req_data,
	input  req_pkg::client_id_t  req_id,
	output logic                 done_valid,
	output req_pkg::client_id_t  done_id,
	output bus_pkg::bus_data_t   done_data,
	output logic                 done_store,
	output logic                 done_err
);

	import bus_pkg::*;

	// processor-memory bus
	bus_cmd_t proc2mem_command;
	bus_addr_t proc2mem_addr;
	bus_data_t proc2mem_data;
	mem_tag_t mem2proc_response;
	bus_data_t mem2proc_data;
	mem_tag_t mem2proc_tag;

	// in-order issue, out-of-order completion
	mem_req_queue queue_i (
		.clock             (clock),
		.rst               (rst),
		.req_valid         (req_valid),
		.req_ready         (req_ready),
		.req_cmd           (req_cmd),
		.req_addr          (req_addr),
		.req_data          (req_data),
		.req_id            (req_id),
		.done_valid        (done_valid),
		.done_id           (done_id),
		.done_data         (done_data),
		.done_store        (done_store),
		.done_err          (done_err),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.proc2mem_data     (proc2mem_data),
		.mem2proc_response (mem2proc_response),
		.mem2proc_data     (mem2proc_data),
		.mem2proc_tag      (mem2proc_tag)
	);

	// tagged main memory
	mem mem_i (
		.clock             (clock),
		.rst               (rst),
		.proc2mem_addr     (proc2mem_addr),
		.proc2mem_data     (proc2mem_data),
		.proc2mem_command  (proc2mem_command),
		.mem2proc_response (mem2proc_response),
		.mem2proc_data     (mem2proc_data),
		.mem2proc_tag      (mem2proc_tag)
	);

endmodule

`default_nettype wire

// File: rtl/req_pkg.sv
`default_nettype none

`include "mem_config.svh"

//////////////////////////////
// request queue types
//////////////////////////////

package req_pkg;

	// id picked by the client, echoed on completion
	typedef logic [3:0] client_id_t;

	// entry index into the circular buffer
	typedef logic [$clog2(`REQ_QUEUE_DEPTH)-1:0] queue_idx_t;

	// idle drives a command, wait checks the response
	typedef enum logic {ISSUE_IDLE, ISSUE_WAIT} issue_state_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the mem_subsys testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter project directory"
	exit 1
fi

LOG=sim.log

verilator --binary --timing --top-module mem_subsys_tb -f mem_subsys.f -o mem_subsys_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mem_subsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

// File: sim/mem_subsys_tb.sv
`default_nettype none

`include "mem_config.svh"

module mem_subsys_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import bus_pkg::*;
	import req_pkg::*;

	localparam int LINE_W = $clog2(`MEM_64BIT_LINES);
	// cycles any single wait may take
	localparam int WAIT_LIMIT = 400;

	logic clock;
	logic rst;
	logic req_valid;
	logic req_ready;
	bus_cmd_t req_cmd;
	bus_addr_t req_addr;
	bus_data_t req_data;
	client_id_t req_id;
	logic done_valid;
	client_id_t done_id;
	bus_data_t done_data;
	logic done_store;
	logic done_err;

	// reference memory in program order
	bus_data_t model_mem [`MEM_64BIT_LINES];
	// expected completion per client id
	bus_data_t exp_data [16];
	logic [15:0] exp_store;
	logic [15:0] exp_err;
	logic [15:0] outstanding;
	logic ready_low_seen;
	logic [31:0] lfsr;

	mem_subsys mem_subsys_i (
		.clock      (clock),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_cmd    (req_cmd),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.req_id     (req_id),
		.done_valid (done_valid),
		.done_id    (done_id),
		.done_data  (done_data),
		.done_store (done_store),
		.done_err   (done_err)
	);

	// 40 ns period
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	//////////////////////////////
	// checking helpers
	//////////////////////////////

	task automatic abort(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			abort($sformatf("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	// galois lfsr with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	// one lfsr step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], lfsr_bit()};
		return v;
	endfunction

	// word pattern built from every address bit
	function automatic bus_data_t pattern(input bus_addr_t addr);
		return {addr[31:0] ^ addr[63:32] ^ 32'hc3a5_5a3c, ~addr[31:0]};
	endfunction

	//////////////////////////////
	// bus tasks
	//////////////////////////////

	// advance to the next falling edge and score any completion
	task automatic tick();
		@(negedge clock);
		if (done_valid === 1'b1) begin
			if (!outstanding[done_id])
				abort($sformatf("completion for id %0d which was not outstanding", done_id));
			compare($sformatf("done_err id %0d", done_id), 64'(done_err),
				64'(exp_err[done_id]));
			compare($sformatf("done_store id %0d", done_id), 64'(done_store),
				64'(exp_store[done_id]));
			// only good loads carry data back
			if (!exp_err[done_id] && !exp_store[done_id])
				compare($sformatf("load data id %0d", done_id), done_data,
					exp_data[done_id]);
			outstanding[done_id] = 1'b0;
		end else if (done_valid !== 1'b0) begin
			abort("done_valid is unknown");
		end
	endtask

	// one request strobe once req_ready is high
	task automatic send(input bus_cmd_t cmd, input bus_addr_t addr, input bus_data_t data,
		input client_id_t id);
		int n;
		n = 0;
		while (req_ready !== 1'b1) begin
			if (n == WAIT_LIMIT)
				abort("timeout waiting for req_ready");
			ready_low_seen = 1'b1;
			tick();
			n++;
		end
		// expectation fixed in program order
		outstanding[id] = 1'b1;
		exp_store[id] = (cmd == BUS_STORE);
		exp_err[id] = (addr[2:0] != 3'b000) || (addr >= bus_addr_t'(`MEM_SIZE_IN_BYTES));
		if (!exp_err[id]) begin
			if (cmd == BUS_STORE)
				model_mem[addr[3 +: LINE_W]] = data;
			else
				exp_data[id] = model_mem[addr[3 +: LINE_W]];
		end
		req_valid = 1'b1;
		req_cmd = cmd;
		req_addr = addr;
		req_data = data;
		req_id = id;
		tick();
		req_valid = 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (outstanding != '0) begin
			if (n == WAIT_LIMIT)
				abort("timeout waiting for outstanding completions");
			tick();
			n++;
		end
	endtask

	task automatic wait_id_free(input client_id_t id);
		int n;
		n = 0;
		while (outstanding[id]) begin
			if (n == WAIT_LIMIT)
				abort($sformatf("timeout waiting for id %0d to complete", id));
			tick();
			n++;
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic reset_and_idle();
		rst = 1'b1;
		repeat (5) @(negedge clock);
		rst = 1'b0;
		compare("req_ready after reset", 64'(req_ready), 64'd1);
		for (int i = 0; i < 10; i++) begin
			tick();
			compare("done_valid while idle", 64'(done_valid), 64'd0);
			compare("req_ready while idle", 64'(req_ready), 64'd1);
		end
		// first and last word still read zero
		send(BUS_LOAD, 64'h0, '0, 4'd1);
		send(BUS_LOAD, bus_addr_t'(`MEM_SIZE_IN_BYTES - 8), '0, 4'd2);
		drain();
	endtask

	task automatic store_then_load();
		send(BUS_STORE, 64'h40, 64'hdead_beef_0123_4567, 4'd2);
		send(BUS_LOAD, 64'h40, '0, 4'd3);
		drain();
	endtask

	task automatic reject_bad_addr();
		send(BUS_LOAD, 64'h44, '0, 4'd4);
		// would alias line 0 if not caught
		send(BUS_STORE, bus_addr_t'(`MEM_SIZE_IN_BYTES), 64'h1111_2222_3333_4444, 4'd5);
		// would alias line 8
		send(BUS_STORE, 64'h43, 64'h5555_6666_7777_8888, 4'd6);
		send(BUS_LOAD, 64'h0, '0, 4'd7);
		send(BUS_LOAD, 64'h40, '0, 4'd8);
		drain();
	endtask

	task automatic flood_loads();
		bus_addr_t addr;
		for (int i = 0; i < 16; i++) begin
			addr = bus_addr_t'(64'h100 + 40 * i);
			send(BUS_STORE, addr, pattern(addr), client_id_t'(i));
		end
		drain();
		ready_low_seen = 1'b0;
		// more loads than the queue holds, sent back to back
		for (int i = 0; i < 16; i++)
			send(BUS_LOAD, bus_addr_t'(64'h100 + 40 * i), '0, client_id_t'(15 - i));
		drain();
		compare("req_ready dropped under load", 64'(ready_low_seen), 64'd1);
	endtask

	task automatic random_mix();
		client_id_t id;
		bus_cmd_t cmd;
		bus_addr_t addr;
		bus_data_t data;
		id = '0;
		for (int i = 0; i < 200; i++) begin
			// ids come back only after completion
			wait_id_free(id);
			cmd = (rand_bits(1) != 0) ? BUS_STORE : BUS_LOAD;
			// 32 lines so loads hit earlier stores
			addr = rand_bits(5) << 3;
			data = rand_bits(64);
			send(cmd, addr, data, id);
			if (rand_bits(2) == 0)
				tick();
			id = id + 1'b1;
		end
		drain();
		// nothing stray may follow
		repeat (20) tick();
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_cmd = BUS_NONE;
		req_addr = '0;
		req_data = '0;
		req_id = '0;
		outstanding = '0;
		exp_store = '0;
		exp_err = '0;
		ready_low_seen = 1'b0;
		lfsr = 32'h45c3a583;
		for (int i = 0; i < `MEM_64BIT_LINES; i++)
			model_mem[i] = '0;
		for (int i = 0; i < 16; i++)
			exp_data[i] = '0;
		reset_and_idle();
		store_then_load();
		reject_bad_addr();
		flood_loads();
		random_mix();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
